// ==== design/byte_rx_pkg.sv ====
`default_nettype none

package byte_rx_pkg;

	////////////////////////////////////////
	// Data types

	// One big-endian word, first byte in bits 31:24
	typedef logic [31:0] word_t;

	// Bytes carried by one stream write, 1 to 4
	typedef logic [2:0] byte_count_t;

	// Byte address on the APB side
	typedef logic [3:0] apb_addr_t;

	////////////////////////////////////////
	// Register map

	localparam apb_addr_t REG_DATA    = 4'h0;
	localparam apb_addr_t REG_STATUS  = 4'h4;
	localparam apb_addr_t REG_ERR_CLR = 4'h8;

	////////////////////////////////////////
	// STATUS bit positions

	localparam int STAT_EMPTY     = 0;
	localparam int STAT_FULL      = 1;
	localparam int STAT_OVERFLOW  = 2;
	localparam int STAT_UNDERFLOW = 3;

	// Occupancy field starts here and is as wide as the FIFO count
	localparam int STAT_RSIZE_LSB = 16;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input wire clk,
	input wire rst,

	// Push side
	input wire wr,
	input wire byte_rx_pkg::word_t din,

	// Pop side, data one cycle after rd
	input wire rd,
	output byte_rx_pkg::word_t dout,

	// Flags and occupancy
	output logic empty,
	output logic full,
	output logic overflow,
	output logic underflow,
	output logic [AW:0] rsize
);

	import byte_rx_pkg::*;

	////////////////////////////////////////
	// Storage and pointers

	// Word array, no reset on contents
	word_t mem [DEPTH];

	// Pointers carry one extra wrap bit
	logic [AW:0] wptr;
	logic [AW:0] rptr;

	// Accepted operations
	logic wr_ok;
	logic rd_ok;

	// Depth must be a power of two, at least two
	if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
		$error("sync_fifo: DEPTH must be a power of two and at least 2");
	end

	////////////////////////////////////////
	// Flags

	// Same address, same lap means empty
	assign empty = (wptr == rptr);

	// Same address, different lap means full
	assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

	// Pointer difference is the number of stored words
	assign rsize = wptr - rptr;

	// Illegal operations are dropped
	assign wr_ok = wr && !full;
	assign rd_ok = rd && !empty;

	////////////////////////////////////////
	// Write port

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wptr[AW-1:0]] <= din;
		end
	end

	////////////////////////////////////////
	// Read port

	// Output register only moves on a real pop
	always_ff @(posedge clk) begin
		if (rd_ok) begin
			dout <= mem[rptr[AW-1:0]];
		end
	end

	////////////////////////////////////////
	// Pointer and error pulse state

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr      <= '0;
			rptr      <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wptr <= wptr + 1'b1;
			end
			if (rd_ok) begin
				rptr <= rptr + 1'b1;
			end

			// One-cycle pulses for dropped operations
			overflow  <= wr && full;
			underflow <= rd && empty;
		end
	end

	////////////////////////////////////////
	// Checks

	// Occupancy can never pass the array size
	a_rsize_bound: assert property (@(posedge clk) disable iff (rst)
		rsize <= DEPTH);

endmodule

`default_nettype wire

// ==== design/byte_input_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_input_fifo #(
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input wire clk,
	input wire rst,

	// Byte stream, left-justified in din
	input wire wr,
	input wire byte_rx_pkg::word_t din,
	input wire byte_rx_pkg::byte_count_t bytes_valid,
	input wire flush,

	// Word read side
	input wire rd,
	output byte_rx_pkg::word_t dout,

	// Status toward the register block
	output logic empty,
	output logic full,
	output logic overflow,
	output logic underflow,
	output logic [AW:0] rsize
);

	import byte_rx_pkg::*;

	////////////////////////////////////////
	// Holding register

	// Up to three leftover bytes, oldest in bits 23:16
	logic [23:0] hold_data;
	logic [1:0] hold_cnt;

	// Incoming bytes with unused lanes forced to zero
	word_t din_mask;
	word_t din_clean;

	// Seven-byte merge window, oldest byte in bits 55:48
	logic [55:0] window;
	byte_count_t merged_cnt;

	// Push toward the word FIFO
	logic push_full;
	logic push_flush;
	logic fifo_wr;
	word_t fifo_din;

	// Raw FIFO occupancy
	logic [AW:0] fifo_rsize;

	////////////////////////////////////////
	// Merge logic

	// Keep only the top bytes_valid lanes
	assign din_mask = 32'hffff_ffff << (8 * (4 - bytes_valid));
	assign din_clean = din & din_mask;

	always_comb begin
		// Held bytes always sit at the top of the window
		window = {hold_data, 32'h0};
		merged_cnt = {1'b0, hold_cnt};

		// New bytes land right after the held ones
		if (wr) begin
			window = window | ({24'h0, din_clean} << (8 * (3 - hold_cnt)));
			merged_cnt = hold_cnt + bytes_valid;
		end
	end

	// A full word is ready as soon as four bytes are present
	assign push_full = (merged_cnt >= 3'd4);

	// Flush only pushes when something is held
	assign push_flush = flush && (hold_cnt != 2'd0);

	assign fifo_wr = push_full || push_flush;

	// Partial word is zero-padded at the bottom
	assign fifo_din = push_full ? window[55:24] : {hold_data, 8'h0};

	////////////////////////////////////////
	// Holding register update

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_data <= '0;
			hold_cnt  <= '0;
		end else if (push_full) begin
			// Leftover bytes after the pushed word
			hold_data <= window[23:0];
			hold_cnt  <= 2'(merged_cnt - 3'd4);
		end else if (flush) begin
			hold_data <= '0;
			hold_cnt  <= '0;
		end else begin
			// Not enough for a word yet
			hold_data <= window[55:32];
			hold_cnt  <= merged_cnt[1:0];
		end
	end

	////////////////////////////////////////
	// Word FIFO

	sync_fifo #(
		.DEPTH(DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.wr(fifo_wr),
		.din(fifo_din),
		.rd(rd),
		.dout(dout),
		.empty(empty),
		.full(full),
		.overflow(overflow),
		.underflow(underflow),
		.rsize(fifo_rsize)
	);

	// A partial word counts as one more
	assign rsize = fifo_rsize + (hold_cnt != 2'd0);

	////////////////////////////////////////
	// Checks

	// Producer keeps flush apart from writes
	a_no_wr_flush: assert property (@(posedge clk) disable iff (rst)
		!(wr && flush));

	// Byte count is legal on every write
	a_bytes_valid: assert property (@(posedge clk) disable iff (rst)
		wr |-> (bytes_valid >= 3'd1 && bytes_valid <= 3'd4));

endmodule

`default_nettype wire

// ==== design/apb_rx_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_rx_regs #(
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input wire clk,
	input wire rst,

	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire byte_rx_pkg::apb_addr_t paddr,
	input wire byte_rx_pkg::word_t pwdata,
	output byte_rx_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,

	// Word FIFO side
	output logic rd,
	input wire byte_rx_pkg::word_t dout,
	input wire empty,
	input wire full,
	input wire overflow,
	input wire underflow,
	input wire [AW:0] rsize
);

	import byte_rx_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_DATA_WAIT
	} state_t;

	state_t state;
	state_t state_next;

	// Access phase of a transfer
	logic access;

	// Address decode
	logic sel_data;
	logic sel_status;
	logic sel_err_clr;

	// Error flags held until cleared
	logic ovf_sticky;
	logic unf_sticky;
	logic clr_write;

	word_t status_word;

	////////////////////////////////////////
	// Decode

	assign access = psel && penable;
	assign sel_data = (paddr == REG_DATA);
	assign sel_status = (paddr == REG_STATUS);
	assign sel_err_clr = (paddr == REG_ERR_CLR);
	assign clr_write = (state == ST_IDLE) && access && pwrite && sel_err_clr;

	// Status fields at their package positions
	always_comb begin
		status_word = '0;
		status_word[STAT_EMPTY] = empty;
		status_word[STAT_FULL] = full;
		status_word[STAT_OVERFLOW] = ovf_sticky;
		status_word[STAT_UNDERFLOW] = unf_sticky;
		status_word[STAT_RSIZE_LSB +: AW+1] = rsize;
	end

	////////////////////////////////////////
	// Transfer control

	always_comb begin
		state_next = state;
		rd = 1'b0;
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;

		if (state == ST_DATA_WAIT) begin
			// Popped word is on dout now
			if (access) begin
				pready = 1'b1;
				prdata = dout;
				state_next = ST_IDLE;
			end
		end else if (access) begin
			pready = 1'b1;
			if (sel_data && !pwrite && !empty) begin
				// One wait state while the FIFO output loads
				rd = 1'b1;
				pready = 1'b0;
				state_next = ST_DATA_WAIT;
			end else if (sel_data && !pwrite) begin
				// Nothing to read, return zero with an error
				pslverr = 1'b1;
			end else if (sel_status && !pwrite) begin
				prdata = status_word;
			end else if (sel_err_clr && !pwrite) begin
				// Reading back the clear register shows the sticky bits
				prdata[STAT_OVERFLOW] = ovf_sticky;
				prdata[STAT_UNDERFLOW] = unf_sticky;
			end else if (!(sel_data || sel_status || sel_err_clr)) begin
				pslverr = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////
	// Sticky error flags

	// A new pulse wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			ovf_sticky <= 1'b0;
			unf_sticky <= 1'b0;
		end else begin
			ovf_sticky <= (ovf_sticky && !(clr_write && pwdata[STAT_OVERFLOW])) || overflow;
			unf_sticky <= (unf_sticky && !(clr_write && pwdata[STAT_UNDERFLOW])) || underflow;
		end
	end

	////////////////////////////////////////
	// Checks

	// Pop only when the FIFO holds a word
	a_rd_not_empty: assert property (@(posedge clk) disable iff (rst)
		rd |-> !empty);

	// Each DATA read pops once and completes in the next cycle
	a_rd_single: assert property (@(posedge clk) disable iff (rst)
		rd |=> (!rd && pready));

endmodule

`default_nettype wire

// ==== design/byte_rx_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_rx_subsys #(
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input wire clk,
	input wire rst,

	// Byte stream input
	input wire wr,
	input wire byte_rx_pkg::word_t din,
	input wire byte_rx_pkg::byte_count_t bytes_valid,
	input wire flush,

	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire byte_rx_pkg::apb_addr_t paddr,
	input wire byte_rx_pkg::word_t pwdata,
	output byte_rx_pkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	import byte_rx_pkg::*;

	////////////////////////////////////////
	// Word FIFO to register block

	logic fifo_rd;
	word_t fifo_dout;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_overflow;
	logic fifo_underflow;
	logic [AW:0] fifo_rsize;

	// Byte packer with its word FIFO
	byte_input_fifo #(
		.DEPTH(DEPTH)
	) u_byte_input_fifo (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.din(din),
		.bytes_valid(bytes_valid),
		.flush(flush),
		.rd(fifo_rd),
		.dout(fifo_dout),
		.empty(fifo_empty),
		.full(fifo_full),
		.overflow(fifo_overflow),
		.underflow(fifo_underflow),
		.rsize(fifo_rsize)
	);

	// Register block that drains the FIFO
	apb_rx_regs #(
		.DEPTH(DEPTH)
	) u_apb_rx_regs (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rd(fifo_rd),
		.dout(fifo_dout),
		.empty(fifo_empty),
		.full(fifo_full),
		.overflow(fifo_overflow),
		.underflow(fifo_underflow),
		.rsize(fifo_rsize)
	);

endmodule

`default_nettype wire

// ==== dv/byte_rx_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_rx_subsys_tb;

	import byte_rx_pkg::*;

	localparam int DEPTH = 16;

	// Clock and reset
	logic clk = 1'b0;
	logic rst;

	// Stream side
	logic wr;
	word_t din;
	byte_count_t bytes_valid;
	logic flush;

	// APB side
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;

	// Parsed vector lines
	byte cmd_q[$];
	word_t arg0_q[$];
	word_t arg1_q[$];
	word_t arg2_q[$];

	// Bytes not yet in a word and the words the FIFO should hold
	byte hold_q[$];
	word_t exp_q[$];

	word_t rnd_state = 32'ha4b8_cf59;
	int cycle_count = 0;
	int cycle_limit = 1000000;

	byte_rx_subsys #(
		.DEPTH(DEPTH)
	) UUT (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.din(din),
		.bytes_valid(bytes_valid),
		.flush(flush),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////
	// Failure handling and compares

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_status(input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED at %0t: STATUS expected %h, got %h", $time, exp, act);
			stop_run();
		end
	endtask

	task automatic check_err(input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED at %0t: pslverr expected %b, got %b", $time, exp, act);
			stop_run();
		end
	endtask

	// Run is bounded by the length of the loaded tests
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
			stop_run();
		end
	end

	////////////////////////////////////////
	// Packing model

	// 32-bit xorshift step
	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// A full FIFO drops the word
	task automatic model_store(input word_t w);
		if (exp_q.size() < DEPTH) begin
			exp_q.push_back(w);
		end
	endtask

	// Bytes arrive first from the top lane
	task automatic model_write(input byte_count_t cnt, input word_t data);
		word_t w;
		for (int i = 0; i < cnt; i++) begin
			hold_q.push_back(data[31 - 8 * i -: 8]);
		end
		while (hold_q.size() >= 4) begin
			w = {hold_q[0], hold_q[1], hold_q[2], hold_q[3]};
			repeat (4) void'(hold_q.pop_front());
			model_store(w);
		end
	endtask

	// Partial word padded with zero bytes at the bottom
	task automatic model_flush();
		word_t w;
		w = '0;
		for (int i = 0; i < hold_q.size(); i++) begin
			w[31 - 8 * i -: 8] = hold_q[i];
		end
		if (hold_q.size() > 0) begin
			model_store(w);
		end
		hold_q.delete();
	endtask

	////////////////////////////////////////
	// Bus drivers

	task automatic stream_write(input byte_count_t cnt, input word_t data);
		@(posedge clk);
		wr <= 1'b1;
		din <= data;
		bytes_valid <= cnt;
		flush <= 1'b0;
	endtask

	task automatic stream_idle();
		@(posedge clk);
		wr <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic stream_flush();
		@(posedge clk);
		wr <= 1'b0;
		flush <= 1'b1;
		stream_idle();
	endtask

	// Setup phase and then access phase until pready is seen at the falling edge
	task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
			output word_t rdata, output logic err, output int waits);
		waits = 0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			waits++;
			if (waits > 2) begin
				$display("APB access to address %h never completed", addr);
				stop_run();
			end
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	// Accesses that pop nothing finish in the first access cycle
	task automatic access_no_wait(input logic write, input apb_addr_t addr, input word_t wdata,
			output word_t rdata, output logic err);
		int waits;
		apb_access(write, addr, wdata, rdata, err, waits);
		if (waits != 0) begin
			$display("Access to address %h at %0t took %0d wait states", addr, $time, waits);
			stop_run();
		end
	endtask

	// DATA read takes one wait state only when a word is popped
	task automatic read_data(input logic exp_err, output word_t data, output logic err);
		int waits;
		apb_access(1'b0, REG_DATA, '0, data, err, waits);
		if (waits != (exp_err ? 0 : 1)) begin
			$display("DATA read at %0t took %0d wait states", $time, waits);
			stop_run();
		end
	endtask

	////////////////////////////////////////
	// Vector file

	task automatic load_vectors();
		int fd;
		int weight;
		int longest;
		byte c;
		string line;
		word_t a0;
		word_t a1;
		word_t a2;
		weight = 0;
		longest = 0;
		fd = $fopen("dv/byte_rx_subsys_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file dv/byte_rx_subsys_vectors.txt");
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			c = line.getc(0);
			// Skip comments and blank lines
			if (c == "#" || c == "\n" || c == "\r" || c == " ") begin
				continue;
			end
			a0 = '0;
			a1 = '0;
			a2 = '0;
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a0, a1, a2));
			cmd_q.push_back(c);
			arg0_q.push_back(a0);
			arg1_q.push_back(a1);
			arg2_q.push_back(a2);
			weight += (c == "W") ? a2 : (c == "R") ? a0 : 1;
			if (c == "B" && a0 > longest) begin
				longest = a0;
			end
		end
		$fclose(fd);
		cycle_limit = 20 * weight + 20 * longest + 16;
	endtask

	task automatic run_command(input byte c, input word_t a0, input word_t a1, input word_t a2);
		word_t rdata;
		word_t data;
		logic err;
		byte_count_t cnt;
		case (c)
			"W": begin
				// Repeated writes step the data by one
				for (int k = 0; k < a2; k++) begin
					stream_write(a0[2:0], a1 + k);
					model_write(a0[2:0], a1 + k);
				end
				stream_idle();
			end
			"F": begin
				stream_flush();
				model_flush();
			end
			"D": begin
				read_data(a1[0], rdata, err);
				check_word("prdata", a0, rdata);
				check_err(a1[0], err);
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
			end
			"R": begin
				for (int k = 0; k < a0; k++) begin
					if (exp_q.size() == 0) begin
						$display("Vector asks for more words than the model holds");
						stop_run();
					end
					read_data(1'b0, rdata, err);
					check_word("prdata", exp_q.pop_front(), rdata);
					check_err(1'b0, err);
				end
			end
			"S": begin
				access_no_wait(1'b0, REG_STATUS, '0, rdata, err);
				check_status(a0, rdata);
				check_err(1'b0, err);
			end
			"C": begin
				access_no_wait(1'b1, REG_ERR_CLR, a0, rdata, err);
				check_err(1'b0, err);
			end
			"U": begin
				access_no_wait(1'b0, a0[3:0], '0, rdata, err);
				check_err(1'b1, err);
			end
			"B": begin
				// Back-to-back random writes and a flush before draining everything
				for (int k = 0; k < a0; k++) begin
					rnd_state = xorshift(rnd_state);
					cnt = byte_count_t'(rnd_state[1:0]) + 3'd1;
					rnd_state = xorshift(rnd_state);
					data = rnd_state;
					stream_write(cnt, data);
					model_write(cnt, data);
				end
				stream_flush();
				model_flush();
				while (exp_q.size() > 0) begin
					read_data(1'b0, rdata, err);
					check_word("prdata", exp_q.pop_front(), rdata);
					check_err(1'b0, err);
				end
			end
			default: begin
				$display("Unknown command %c in the vector file", c);
				stop_run();
			end
		endcase
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		rst = 1'b1;
		wr = 1'b0;
		din = '0;
		bytes_valid = 3'd1;
		flush = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		load_vectors();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < cmd_q.size(); i++) begin
			run_command(cmd_q[i], arg0_q[i], arg1_q[i], arg2_q[i]);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== byte_rx_subsys.f ====
design/byte_rx_pkg.sv
design/sync_fifo.sv
design/byte_input_fifo.sv
design/apb_rx_regs.sv
design/byte_rx_subsys.sv
dv/byte_rx_subsys_tb.sv

// ==== dv/byte_rx_subsys_vectors.txt ====
# cmd args in hex: W count data repeats | F | D word pslverr | S status | C clear_bits
# U unmapped_addr | R words_from_model | B burst_writes
S 00000001
W 1 11000000 1
W 1 22000000 1
W 1 33000000 1
S 00010001
W 1 44000000 1
W 2 55660000 1
W 2 77880000 1
S 00020000
D 11223344 0
D 55667788 0
W 3 a1b2c3ff 1
S 00010001
F
S 00010000
F
S 00010000
D a1b2c300 0
S 00000001
W 4 c0de0000 11
S 00100006
R 10
S 00000005
C 4
S 00000001
D 00000000 1
S 00000001
U c
U 2
B 0c
S 00000001
